// File: design/tim_fabric_pkg.sv
package tim_fabric_pkg;

  //////////////////////////////////////////////////////////////////////
  // bank geometry
  //////////////////////////////////////////////////////////////////////

  localparam int N_BANKS    = 2;
  localparam int BANK_WORDS = 64;
  localparam int INDEX_W    = $clog2(BANK_WORDS);
  localparam int WINDOW_W   = 32 - INDEX_W - 2;

  // bank 0 is instruction memory, bank 1 is data memory
  localparam logic [31:0] BANK_BASE [N_BANKS] = '{
    32'h1000_0000,
    32'h2000_0000
  };

  // byte span of one bank, 256 bytes for 64 words
  localparam logic [31:0] BANK_MASK = 32'(BANK_WORDS * 4 - 1);

  //////////////////////////////////////////////////////////////////////
  // owner tags
  //////////////////////////////////////////////////////////////////////

  typedef logic [0:0] port_tag_t;

  localparam port_tag_t TAG_FETCH = 1'b0;
  localparam port_tag_t TAG_DATA  = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // address views
  //////////////////////////////////////////////////////////////////////

  // flat for window compare, fields for bank indexing
  typedef union packed {
    logic [31:0] flat;
    struct packed {
      logic [WINDOW_W-1:0] window;
      logic [INDEX_W-1:0]  index;
      logic [1:0]          offset;
    } fields;
  } tim_addr_u;

endpackage

// File: design/mem_bus_if.sv
`timescale 1ns/100ps

interface mem_bus_if;
  import tim_fabric_pkg::*;

  // request side
  logic        valid;
  tim_addr_u   addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  port_tag_t   tag;

  // response side, rtag names the owner of the response
  logic [31:0] rdata;
  logic        ready;
  logic        error;
  port_tag_t   rtag;

  modport requester (
    output valid, addr, wdata, wstrb, tag,
    input  rdata, ready, error, rtag
  );

  modport responder (
    input  valid, addr, wdata, wstrb, tag,
    output rdata, ready, error, rtag
  );

endinterface

// File: design/request_router.sv
`timescale 1ns/100ps

module request_router (
  input logic        clock,
  input logic        reset,
  mem_bus_if.responder fetch_bus,
  mem_bus_if.responder data_bus,
  mem_bus_if.requester bank_bus [tim_fabric_pkg::N_BANKS],
  output logic       fetch_miss,
  output logic       data_miss
);
  import tim_fabric_pkg::*;

  logic [N_BANKS-1:0] fetch_hit;
  logic [N_BANKS-1:0] data_hit;

  //////////////////////////////////////////////////////////////////////
  // per-bank decode and arbitration
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    tim_addr_u fetch_rebased;
    tim_addr_u data_rebased;

    assign fetch_hit[b] = fetch_bus.valid &
                          ((fetch_bus.addr.flat & ~BANK_MASK) == BANK_BASE[b]);
    assign data_hit[b]  = data_bus.valid &
                          ((data_bus.addr.flat & ~BANK_MASK) == BANK_BASE[b]);

    // strip the window base so the bank sees an offset from zero
    assign fetch_rebased = fetch_bus.addr.flat - BANK_BASE[b];
    assign data_rebased  = data_bus.addr.flat - BANK_BASE[b];

    // fetch wins a shared bank, the data request waits with valid held
    assign bank_bus[b].valid = fetch_hit[b] | data_hit[b];
    assign bank_bus[b].addr  = fetch_hit[b] ? fetch_rebased : data_rebased;
    assign bank_bus[b].wdata = fetch_hit[b] ? fetch_bus.wdata : data_bus.wdata;
    assign bank_bus[b].wstrb = fetch_hit[b] ? fetch_bus.wstrb : data_bus.wstrb;
    assign bank_bus[b].tag   = fetch_hit[b] ? fetch_bus.tag : data_bus.tag;
  end

  //////////////////////////////////////////////////////////////////////
  // unmapped requests
  //////////////////////////////////////////////////////////////////////

  // one-cycle strobe, lines up with the bank response timing
  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      fetch_miss <= 1'b0;
      data_miss  <= 1'b0;
    end else begin
      fetch_miss <= fetch_bus.valid & ~|fetch_hit;
      data_miss  <= data_bus.valid & ~|data_hit;
    end
  end

endmodule

// File: design/tim_bank.sv
`timescale 1ns/100ps

module tim_bank (
  input logic          clock,
  input logic          reset,
  mem_bus_if.responder bus
);
  import tim_fabric_pkg::*;

  logic [31:0] mem [BANK_WORDS];

  logic [INDEX_W-1:0] index;

  assign index = bus.addr.fields.index;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (bus.valid) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.wstrb[i]) begin
          mem[index][i*8 +: 8] <= bus.wdata[i*8 +: 8];
        end
      end
    end
  end

  // read data only moves on a read, writes leave it alone
  always_ff @(posedge clock) begin
    if (bus.valid && bus.wstrb == 4'b0000) begin
      bus.rdata <= mem[index];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      bus.ready <= 1'b0;
      bus.rtag  <= TAG_FETCH;
    end else begin
      bus.ready <= bus.valid;
      if (bus.valid) begin
        bus.rtag <= bus.tag;
      end
    end
  end

  // every in-window word exists, so the bank never faults
  assign bus.error = 1'b0;

endmodule

// File: design/response_merger.sv
`timescale 1ns/100ps

module response_merger (
  mem_bus_if.requester bank_bus [tim_fabric_pkg::N_BANKS],
  input  logic         fetch_miss,
  input  logic         data_miss,
  output logic [31:0]  fetch_rdata,
  output logic         fetch_ready,
  output logic         fetch_error,
  output logic [31:0]  data_rdata,
  output logic         data_ready,
  output logic         data_error
);
  import tim_fabric_pkg::*;

  logic [N_BANKS-1:0] bank_ready;
  logic [N_BANKS-1:0] bank_error;
  port_tag_t          bank_rtag  [N_BANKS];
  logic [31:0]        bank_rdata [N_BANKS];

  // flatten the interface array so the select loop can index it
  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    assign bank_ready[b] = bank_bus[b].ready;
    assign bank_error[b] = bank_bus[b].error;
    assign bank_rtag[b]  = bank_bus[b].rtag;
    assign bank_rdata[b] = bank_bus[b].rdata;
  end

  //////////////////////////////////////////////////////////////////////
  // steering
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fetch_rdata = '0;
    fetch_ready = 1'b0;
    fetch_error = 1'b0;
    data_rdata  = '0;
    data_ready  = 1'b0;
    data_error  = 1'b0;

    // at most one bank answers each port in a cycle
    for (int b = 0; b < N_BANKS; b++) begin
      if (bank_ready[b] && bank_rtag[b] == TAG_FETCH) begin
        fetch_rdata = bank_rdata[b];
        fetch_ready = 1'b1;
        fetch_error = bank_error[b];
      end
      if (bank_ready[b] && bank_rtag[b] == TAG_DATA) begin
        data_rdata = bank_rdata[b];
        data_ready = 1'b1;
        data_error = bank_error[b];
      end
    end

    // unmapped request, zero data with error
    if (!fetch_ready && fetch_miss) begin
      fetch_ready = 1'b1;
      fetch_error = 1'b1;
    end
    if (!data_ready && data_miss) begin
      data_ready = 1'b1;
      data_error = 1'b1;
    end
  end

endmodule

// File: design/tim_fabric.sv
`timescale 1ns/100ps

module tim_fabric (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_valid,
  input  logic [31:0] fetch_addr,
  output logic [31:0] fetch_rdata,
  output logic        fetch_ready,
  output logic        fetch_error,
  input  logic        data_valid,
  input  logic [31:0] data_addr,
  input  logic [31:0] data_wdata,
  input  logic [3:0]  data_wstrb,
  output logic [31:0] data_rdata,
  output logic        data_ready,
  output logic        data_error
);
  import tim_fabric_pkg::*;

  mem_bus_if fetch_bus ();
  mem_bus_if data_bus ();
  mem_bus_if bank_bus [N_BANKS] ();

  logic fetch_miss;
  logic data_miss;

  //////////////////////////////////////////////////////////////////////
  // port side buses
  //////////////////////////////////////////////////////////////////////

  // fetch never writes
  assign fetch_bus.valid = fetch_valid;
  assign fetch_bus.addr  = fetch_addr;
  assign fetch_bus.wdata = '0;
  assign fetch_bus.wstrb = 4'b0000;
  assign fetch_bus.tag   = TAG_FETCH;

  assign data_bus.valid = data_valid;
  assign data_bus.addr  = data_addr;
  assign data_bus.wdata = data_wdata;
  assign data_bus.wstrb = data_wstrb;
  assign data_bus.tag   = TAG_DATA;

  //////////////////////////////////////////////////////////////////////
  // router, banks, merger
  //////////////////////////////////////////////////////////////////////

  request_router u_router (
    .clock     (clock),
    .reset     (reset),
    .fetch_bus (fetch_bus),
    .data_bus  (data_bus),
    .bank_bus  (bank_bus),
    .fetch_miss(fetch_miss),
    .data_miss (data_miss)
  );

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    tim_bank u_bank (
      .clock(clock),
      .reset(reset),
      .bus  (bank_bus[b])
    );
  end

  response_merger u_merger (
    .bank_bus   (bank_bus),
    .fetch_miss (fetch_miss),
    .data_miss  (data_miss),
    .fetch_rdata(fetch_rdata),
    .fetch_ready(fetch_ready),
    .fetch_error(fetch_error),
    .data_rdata (data_rdata),
    .data_ready (data_ready),
    .data_error (data_error)
  );

endmodule

// File: sim/tim_fabric_properties.sv
`timescale 1ns/100ps

module tim_fabric_properties (
  input logic        clock,
  input logic        reset,
  input logic        fetch_valid,
  input logic        fetch_ready,
  input logic        fetch_error,
  input logic [31:0] fetch_rdata,
  input logic        data_valid,
  input logic        data_ready,
  input logic        data_error,
  input logic [31:0] data_rdata
);

  // a response always belongs to a request from the cycle before
  fetch_ready_has_request: assert property (@(posedge clock) disable iff (reset == 1'b0)
    fetch_ready |-> $past(fetch_valid)) else $error("fetch ready without a request");
  data_ready_has_request: assert property (@(posedge clock) disable iff (reset == 1'b0)
    data_ready |-> $past(data_valid)) else $error("data ready without a request");

  fetch_error_with_ready: assert property (@(posedge clock) disable iff (reset == 1'b0)
    fetch_error |-> fetch_ready) else $error("fetch error without ready");
  data_error_with_ready: assert property (@(posedge clock) disable iff (reset == 1'b0)
    data_error |-> data_ready) else $error("data error without ready");

  fetch_error_zero_data: assert property (@(posedge clock) disable iff (reset == 1'b0)
    fetch_error |-> fetch_rdata == 32'h0) else $error("fetch error with nonzero rdata");
  data_error_zero_data: assert property (@(posedge clock) disable iff (reset == 1'b0)
    data_error |-> data_rdata == 32'h0) else $error("data error with nonzero rdata");

  // outputs come out of reset quiet
  quiet_after_reset: assert property (@(posedge clock)
    $past(reset) == 1'b0 |-> !fetch_ready && !data_ready && !fetch_error && !data_error)
    else $error("response active right after reset");

endmodule

bind tim_fabric tim_fabric_properties u_properties (
  .clock      (clock),
  .reset      (reset),
  .fetch_valid(fetch_valid),
  .fetch_ready(fetch_ready),
  .fetch_error(fetch_error),
  .fetch_rdata(fetch_rdata),
  .data_valid (data_valid),
  .data_ready (data_ready),
  .data_error (data_error),
  .data_rdata (data_rdata)
);

// File: sim/tim_fabric_tb.sv
`timescale 1ns/100ps

module tim_fabric_tb;
  import tim_fabric_pkg::*;

  typedef enum logic [1:0] {
    RESP_NONE,
    RESP_OK,
    RESP_ERR
  } resp_e;

  // one table row, a fetch entry and a data entry with their expected responses
  typedef struct packed {
    int          test;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    resp_e       fetch_exp;
    logic        data_valid;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [3:0]  data_wstrb;
    resp_e       data_exp;
  } row_t;

  logic        clock;
  logic        reset;
  logic        fetch_valid;
  logic [31:0] fetch_addr;
  logic [31:0] fetch_rdata;
  logic        fetch_ready;
  logic        fetch_error;
  logic        data_valid;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [3:0]  data_wstrb;
  logic [31:0] data_rdata;
  logic        data_ready;
  logic        data_error;

  row_t        rows [$];
  logic [31:0] ref_mem [N_BANKS][BANK_WORDS];
  logic [31:0] exp_fetch_rdata;
  logic [31:0] exp_data_rdata;
  logic        exp_data_is_read;
  integer      seed;
  logic        table_ready;
  int          check_count;
  int          fail_count;
  int          test_checks;
  int          test_fails;

  tim_fabric uut (
    .clock      (clock),
    .reset      (reset),
    .fetch_valid(fetch_valid),
    .fetch_addr (fetch_addr),
    .fetch_rdata(fetch_rdata),
    .fetch_ready(fetch_ready),
    .fetch_error(fetch_error),
    .data_valid (data_valid),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_wstrb (data_wstrb),
    .data_rdata (data_rdata),
    .data_ready (data_ready),
    .data_error (data_error)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////

  function automatic int bank_of(input logic [31:0] addr);
    for (int b = 0; b < N_BANKS; b++) begin
      if ((addr & ~BANK_MASK) == BANK_BASE[b]) begin
        return b;
      end
    end
    return -1;
  endfunction

  function automatic int word_of(input logic [31:0] addr);
    return int'(addr[7:2]);
  endfunction

  // expected read data, and the write of a served data request
  task automatic predict(input row_t row);
    int fb;
    int db;
    fb = bank_of(row.fetch_addr);
    db = bank_of(row.data_addr);
    exp_fetch_rdata = 32'h0;
    exp_data_rdata = 32'h0;
    exp_data_is_read = 1'b0;
    if (row.fetch_exp == RESP_OK) begin
      exp_fetch_rdata = ref_mem[fb][word_of(row.fetch_addr)];
    end
    if (row.data_exp == RESP_OK && row.data_wstrb == 4'b0000) begin
      exp_data_rdata = ref_mem[db][word_of(row.data_addr)];
      exp_data_is_read = 1'b1;
    end else if (row.data_exp == RESP_OK) begin
      for (int i = 0; i < 4; i++) begin
        if (row.data_wstrb[i]) begin
          ref_mem[db][word_of(row.data_addr)][i*8 +: 8] = row.data_wdata[i*8 +: 8];
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////

  task automatic add_row(input int test, input logic fv, input logic [31:0] faddr,
                         input resp_e fexp, input logic dv, input logic [31:0] daddr,
                         input logic [31:0] dwdata, input logic [3:0] dwstrb,
                         input resp_e dexp);
    row_t row;
    row = '{test, fv, faddr, fexp, dv, daddr, dwdata, dwstrb, dexp};
    rows.push_back(row);
  endtask

  task automatic fetch_only(input int test, input logic [31:0] addr, input resp_e exp);
    add_row(test, 1'b1, addr, exp, 1'b0, 32'h0, 32'h0, 4'h0, RESP_NONE);
  endtask

  task automatic data_only(input int test, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, input resp_e exp);
    add_row(test, 1'b0, 32'h0, RESP_NONE, 1'b1, addr, wdata, wstrb, exp);
  endtask

  task automatic build_table();
    logic [31:0] w;
    for (int i = 0; i < 3; i++) begin
      add_row(1, 1'b0, 32'h0, RESP_NONE, 1'b0, 32'h0, 32'h0, 4'h0, RESP_NONE);
    end
    w = $random(seed);
    data_only(2, 32'h1000_0010, w, 4'hf, RESP_OK);
    data_only(2, 32'h1000_0010, 32'h0, 4'h0, RESP_OK);
    w = $random(seed);
    data_only(2, 32'h2000_0020, w, 4'hf, RESP_OK);
    data_only(2, 32'h2000_0020, 32'h0, 4'h0, RESP_OK);
    // last word of the window
    w = $random(seed);
    data_only(2, 32'h2000_00fc, w, 4'hf, RESP_OK);
    data_only(2, 32'h2000_00fc, 32'h0, 4'h0, RESP_OK);
    w = $random(seed);
    data_only(3, 32'h2000_0040, w, 4'hf, RESP_OK);
    w = $random(seed);
    data_only(3, 32'h2000_0040, w, 4'b0001, RESP_OK);
    data_only(3, 32'h2000_0040, 32'h0, 4'h0, RESP_OK);
    w = $random(seed);
    data_only(3, 32'h2000_0040, w, 4'b0110, RESP_OK);
    data_only(3, 32'h2000_0040, 32'h0, 4'h0, RESP_OK);
    w = $random(seed);
    data_only(3, 32'h2000_0040, w, 4'b1000, RESP_OK);
    data_only(3, 32'h2000_0040, 32'h0, 4'h0, RESP_OK);
    w = $random(seed);
    data_only(4, 32'h1000_0030, w, 4'hf, RESP_OK);
    w = $random(seed);
    data_only(4, 32'h2000_0044, w, 4'hf, RESP_OK);
    fetch_only(4, 32'h1000_0030, RESP_OK);
    fetch_only(4, 32'h2000_0044, RESP_OK);
    fetch_only(4, 32'h2000_0040, RESP_OK);
    // same bank, the data request is held until it is served
    add_row(5, 1'b1, 32'h1000_0010, RESP_OK, 1'b1, 32'h1000_0030, 32'h0, 4'h0, RESP_NONE);
    data_only(5, 32'h1000_0030, 32'h0, 4'h0, RESP_OK);
    w = $random(seed);
    add_row(5, 1'b1, 32'h2000_0020, RESP_OK, 1'b1, 32'h2000_0024, w, 4'hf, RESP_NONE);
    data_only(5, 32'h2000_0024, w, 4'hf, RESP_OK);
    data_only(5, 32'h2000_0024, 32'h0, 4'h0, RESP_OK);
    add_row(5, 1'b1, 32'h1000_0030, RESP_OK, 1'b1, 32'h2000_0020, 32'h0, 4'h0, RESP_OK);
    w = $random(seed);
    add_row(5, 1'b1, 32'h2000_0044, RESP_OK, 1'b1, 32'h1000_0050, w, 4'hf, RESP_OK);
    fetch_only(5, 32'h1000_0050, RESP_OK);
    data_only(6, 32'h3000_0000, 32'h0, 4'h0, RESP_ERR);
    fetch_only(6, 32'h0000_0000, RESP_ERR);
    add_row(6, 1'b1, 32'h1000_0100, RESP_ERR, 1'b1, 32'h2000_0020, 32'h0, 4'h0, RESP_OK);
    w = $random(seed);
    add_row(6, 1'b1, 32'h1000_0010, RESP_OK, 1'b1, 32'h2000_0100, w, 4'hf, RESP_ERR);
    add_row(6, 1'b0, 32'h0, RESP_NONE, 1'b0, 32'h0, 32'h0, 4'h0, RESP_NONE);
  endtask

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  task automatic check_port(input string port, input resp_e exp, input logic check_rdata,
                            input logic [31:0] exp_rdata, input logic ready,
                            input logic error, input logic [31:0] rdata);
    test_checks++;
    if (exp == RESP_NONE) begin
      assert (!ready && !error) else begin
        $display("[FAIL] %0t: %s port ready %b error %b with no request served",
                 $time, port, ready, error);
        test_fails++;
      end
    end else begin
      assert (ready) else begin
        $display("%s port never gave ready for its request at time %0t", port, $time);
        test_fails++;
      end
      if (ready) begin
        test_checks++;
        assert (error == (exp == RESP_ERR)) else begin
          $display("[FAIL] %0t: %s port error %b, expected %b",
                   $time, port, error, exp == RESP_ERR);
          test_fails++;
        end
        if (exp == RESP_ERR || check_rdata) begin
          test_checks++;
          assert (rdata == exp_rdata) else begin
            $display("[FAIL] %0t: %s port rdata %h, expected %h",
                     $time, port, rdata, exp_rdata);
            test_fails++;
          end
        end
      end
    end
  endtask

  function automatic string test_name(input int test);
    case (test)
      1:       return "idle after reset";
      2:       return "write and read back";
      3:       return "partial writes";
      4:       return "fetch of written data";
      5:       return "bank contention";
      default: return "unmapped addresses";
    endcase
  endfunction

  task automatic check_row(input int r);
    check_port("fetch", rows[r].fetch_exp, rows[r].fetch_exp == RESP_OK, exp_fetch_rdata,
               fetch_ready, fetch_error, fetch_rdata);
    check_port("data", rows[r].data_exp, exp_data_is_read, exp_data_rdata,
               data_ready, data_error, data_rdata);
    if (r == rows.size() - 1 || rows[r + 1].test != rows[r].test) begin
      $display("test %0d %s: %0d checks, %0d errors",
               rows[r].test, test_name(rows[r].test), test_checks, test_fails);
      check_count += test_checks;
      fail_count += test_fails;
      test_checks = 0;
      test_fails = 0;
    end
  endtask

  task automatic drive_row(input row_t row);
    fetch_valid = row.fetch_valid;
    fetch_addr  = row.fetch_addr;
    data_valid  = row.data_valid;
    data_addr   = row.data_addr;
    data_wdata  = row.data_wdata;
    data_wstrb  = row.data_wstrb;
  endtask

  initial begin
    seed = 32'h53b5;
    table_ready = 1'b0;
    check_count = 0;
    fail_count = 0;
    test_checks = 0;
    test_fails = 0;
    reset = 1'b0;
    drive_row('0);
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clock);
    #10;
    reset = 1'b1;
    // responses are sampled mid-cycle, the next row goes in 10 ns after the edge
    for (int r = 0; r <= rows.size(); r++) begin
      @(posedge clock);
      #5;
      if (r > 0) begin
        check_row(r - 1);
      end
      #5;
      if (r < rows.size()) begin
        predict(rows[r]);
        drive_row(rows[r]);
      end else begin
        drive_row('0);
      end
    end
    $display("summary: %0d checks, %0d errors", check_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #(rows.size() * 100 + 20 * 100);
    $display("timeout: the stimulus table did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: tim_fabric.f
design/tim_fabric_pkg.sv
design/mem_bus_if.sv
design/request_router.sv
design/tim_bank.sv
design/response_merger.sv
design/tim_fabric.sv
sim/tim_fabric_properties.sv
sim/tim_fabric_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the tim_fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tim_fabric_tb \
  -Mdir obj_dir \
  -f tim_fabric.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/Vtim_fabric_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'ALL CHECKS PASSED'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
